//--- src/aluPath_cfg.svh
/* Operation codes, register-pair identifiers
   and operand-half select encodings */
`ifndef ALUPATH_CFG_SVH
`define ALUPATH_CFG_SVH

`define OP_ADD 3'd0
`define OP_SUB 3'd1
`define OP_AND 3'd2
`define OP_OR 3'd3
`define OP_XOR 3'd4

`define PAIR_BC 2'd0
`define PAIR_DE 2'd1
`define PAIR_HL 2'd2

// Half select, none leaves the bus at zero
`define SEL_NONE 2'd0
`define SEL_HIGH 2'd1
`define SEL_LOW 2'd2
`define SEL_PAIR 2'd3

`endif

//--- src/aluPathPkg.sv
/* Command, operand word, pipeline stage, result
   and complemented register bus types */
`default_nettype none

package aluPathPkg;

    typedef struct packed {
        logic [1:0] pair;
        logic [1:0] half;
    } operandSelT;

    typedef struct packed {
        logic [2:0] op;
        logic wide;
        operandSelT srcHigh;
        operandSelT srcLow;
        logic [1:0] dstPair;
        logic dstHalf;
        logic spare;
    } aluCmdT;

    typedef struct packed {
        logic [7:0] hiByte;
        logic [7:0] loByte;
    } byteHalvesT;

    // One bus word, read as a pair or as two bytes
    typedef union packed {
        logic [15:0] pairValue;
        byteHalvesT bytes;
    } operandWordU;

    typedef struct packed {
        logic valid;
        logic [2:0] op;
        logic wide;
        logic [1:0] dstPair;
        logic dstHalf;
        operandWordU high;
        operandWordU low;
    } muxStageT;

    typedef struct packed {
        logic [15:0] value;
        logic zero;
        logic carry;
        logic [1:0] dstPair;
        logic dstHalf;
        logic wide;
        logic [1:0] spare;
    } aluResultT;

    // Register outputs, active low as on the register board
    typedef struct packed {
        logic [7:0] notB;
        logic [7:0] notC;
        logic [7:0] notD;
        logic [7:0] notE;
        logic [7:0] notH;
        logic [7:0] notL;
    } pairBusT;

endpackage

`default_nettype wire

//--- src/registerPairFile.sv
/* BC, DE and HL register storage, complemented,
   with byte or whole-pair writeback */
`timescale 1ns/1ns
`default_nettype none
`include "aluPath_cfg.svh"

module registerPairFile import aluPathPkg::*; (
    input wire clk,
    input wire reset,
    input wire writeEnable,
    input wire [15:0] writeValue,
    input wire [1:0] writePair,
    input wire writeWide,
    input wire writeHalf,
    output pairBusT pairBus
);

    logic [7:0] notHigh [3];
    logic [7:0] notLow [3];

    // Zero is held as all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < 3; p++) begin
                notHigh[p] <= 8'hFF;
                notLow[p] <= 8'hFF;
            end
        end else if (writeEnable) begin
            for (int p = 0; p < 3; p++) begin
                if (writePair == 2'(p)) begin
                    if (writeWide) begin
                        notHigh[p] <= ~writeValue[15:8];
                        notLow[p] <= ~writeValue[7:0];
                    end else if (writeHalf) begin
                        notHigh[p] <= ~writeValue[7:0];
                    end else begin
                        notLow[p] <= ~writeValue[7:0];
                    end
                end
            end
        end
    end

    assign pairBus = '{
        notB: notHigh[`PAIR_BC],
        notC: notLow[`PAIR_BC],
        notD: notHigh[`PAIR_DE],
        notE: notLow[`PAIR_DE],
        notH: notHigh[`PAIR_HL],
        notL: notLow[`PAIR_HL]
    };

endmodule

`default_nettype wire

//--- src/commandIssue.sv
/* Command acceptance with read-after-write hazard check,
   issue register and the register file */
`timescale 1ns/1ns
`default_nettype none
`include "aluPath_cfg.svh"

module commandIssue import aluPathPkg::*; (
    input wire clk,
    input wire reset,
    input wire cmdValid,
    input wire aluCmdT cmd,
    input wire stageReady,
    input wire busyMuxValid,
    input wire [1:0] busyMuxPair,
    input wire busyAluValid,
    input wire [1:0] busyAluPair,
    input wire writeEnable,
    input wire [15:0] writeValue,
    input wire [1:0] writePair,
    input wire writeWide,
    input wire writeHalf,
    output logic cmdReady,
    output logic issueValid,
    output aluCmdT issueCmd,
    output pairBusT pairBus
);

    logic hazard;

    function automatic logic readsPair(input aluCmdT c, input logic [1:0] pair);
        return (c.srcHigh.half != `SEL_NONE && c.srcHigh.pair == pair)
            || (c.srcLow.half != `SEL_NONE && c.srcLow.pair == pair);
    endfunction

    // ********************
    // Hazard check
    // ********************
    // An entry waiting here moves on to the mux stage, so it counts too
    assign hazard = (busyMuxValid && readsPair(cmd, busyMuxPair))
                 || (busyAluValid && readsPair(cmd, busyAluPair))
                 || (issueValid && readsPair(cmd, issueCmd.dstPair));

    assign cmdReady = (!issueValid || stageReady) && !hazard;

    always_ff @(posedge clk) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else if (!issueValid || stageReady) begin
            issueValid <= cmdValid && cmdReady;
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid && cmdReady) begin
            issueCmd <= cmd;
        end
    end

    registerPairFile regFile0 (
        .clk(clk),
        .reset(reset),
        .writeEnable(writeEnable),
        .writeValue(writeValue),
        .writePair(writePair),
        .writeWide(writeWide),
        .writeHalf(writeHalf),
        .pairBus(pairBus)
    );

endmodule

`default_nettype wire

//--- src/pairOperandMux.sv
/* Operand selection stage, builds the High and Low buses
   from the complemented register pairs */
`timescale 1ns/1ns
`default_nettype none
`include "aluPath_cfg.svh"

module pairOperandMux import aluPathPkg::*; (
    input wire clk,
    input wire reset,
    input wire issueValid,
    input wire aluCmdT issueCmd,
    input wire pairBusT pairBus,
    input wire aluReady,
    output logic stageReady,
    output muxStageT stageOut,
    output logic busyMuxValid,
    output logic [1:0] busyMuxPair
);

    // Gated NOR per register, an unselected register gives zeros
    function automatic operandWordU placeOperand(input operandSelT sel, input pairBusT regs);
        logic [7:0] notHi;
        logic [7:0] notLo;
        logic hiOnUpper;
        logic hiOnLower;
        logic loOnLower;
        operandWordU word;
        case (sel.pair)
            `PAIR_BC: begin
                notHi = regs.notB;
                notLo = regs.notC;
            end
            `PAIR_DE: begin
                notHi = regs.notD;
                notLo = regs.notE;
            end
            `PAIR_HL: begin
                notHi = regs.notH;
                notLo = regs.notL;
            end
            default: begin
                notHi = 8'hFF;
                notLo = 8'hFF;
            end
        endcase
        hiOnUpper = sel.half == `SEL_PAIR;
        hiOnLower = sel.half == `SEL_HIGH;
        loOnLower = (sel.half == `SEL_LOW) || (sel.half == `SEL_PAIR);
        word.bytes.hiByte = ~(notHi | {8{!hiOnUpper}});
        word.bytes.loByte = ~(notHi | {8{!hiOnLower}}) | ~(notLo | {8{!loOnLower}});
        return word;
    endfunction

    assign stageReady = !stageOut.valid || aluReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            stageOut.valid <= 1'b0;
        end else if (stageReady) begin
            stageOut <= '{
                valid: issueValid,
                op: issueCmd.op,
                wide: issueCmd.wide,
                dstPair: issueCmd.dstPair,
                dstHalf: issueCmd.dstHalf,
                high: placeOperand(issueCmd.srcHigh, pairBus),
                low: placeOperand(issueCmd.srcLow, pairBus)
            };
        end
    end

    assign busyMuxValid = stageOut.valid;
    assign busyMuxPair = stageOut.dstPair;

endmodule

`default_nettype wire

//--- src/aluStage.sv
/* Execute stage: add, subtract and logic operations with
   zero and carry flags, result register and writeback */
`timescale 1ns/1ns
`default_nettype none
`include "aluPath_cfg.svh"

module aluStage import aluPathPkg::*; (
    input wire clk,
    input wire reset,
    input wire muxStageT stageIn,
    input wire resultReady,
    output logic aluReady,
    output logic resultValid,
    output aluResultT result,
    output logic busyAluValid,
    output logic [1:0] busyAluPair,
    output logic writeEnable,
    output logic [15:0] writeValue,
    output logic [1:0] writePair,
    output logic writeWide,
    output logic writeHalf
);

    logic [15:0] opA;
    logic [15:0] opB;
    logic [16:0] raw;
    logic isArith;
    logic [15:0] value;
    logic carry;

    // ********************
    // Datapath
    // ********************
    always_comb begin
        // Narrow operations take the low byte of each bus
        if (stageIn.wide) begin
            opA = stageIn.high.pairValue;
            opB = stageIn.low.pairValue;
        end else begin
            opA = {8'h00, stageIn.high.bytes.loByte};
            opB = {8'h00, stageIn.low.bytes.loByte};
        end
        case (stageIn.op)
            `OP_ADD: raw = {1'b0, opA} + {1'b0, opB};
            `OP_SUB: raw = {1'b0, opA} - {1'b0, opB};
            `OP_AND: raw = {1'b0, opA & opB};
            `OP_OR: raw = {1'b0, opA | opB};
            `OP_XOR: raw = {1'b0, opA ^ opB};
            default: raw = '0;
        endcase
        isArith = (stageIn.op == `OP_ADD) || (stageIn.op == `OP_SUB);
        // Borrow shows up as the bit above the result width
        if (stageIn.wide) begin
            value = raw[15:0];
            carry = isArith && raw[16];
        end else begin
            value = {8'h00, raw[7:0]};
            carry = isArith && raw[8];
        end
    end

    // ********************
    // Result register
    // ********************
    assign aluReady = !resultValid || resultReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
        end else if (aluReady) begin
            resultValid <= stageIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (aluReady && stageIn.valid) begin
            result <= '{
                value: value,
                zero: value == 16'h0000,
                carry: carry,
                dstPair: stageIn.dstPair,
                dstHalf: stageIn.dstHalf,
                wide: stageIn.wide,
                spare: 2'b00
            };
        end
    end

    // Writeback on the acceptance edge
    assign writeEnable = resultValid && resultReady;
    assign writeValue = result.value;
    assign writePair = result.dstPair;
    assign writeWide = result.wide;
    assign writeHalf = result.dstHalf;

    // An entry leaving this edge is already written back
    assign busyAluValid = resultValid && !resultReady;
    assign busyAluPair = result.dstPair;

endmodule

`default_nettype wire

//--- src/aluPathTop.sv
/* Top of the ALU path: issue, operand mux and execute stages */
`timescale 1ns/1ns
`default_nettype none

module aluPathTop import aluPathPkg::*; (
    input wire clk,
    input wire reset,
    input wire cmdValid,
    input wire aluCmdT cmd,
    input wire resultReady,
    output logic cmdReady,
    output logic resultValid,
    output aluResultT result
);

    logic issueValid;
    aluCmdT issueCmd;
    pairBusT pairBus;
    logic stageReady;
    muxStageT muxStage;
    logic aluReady;
    logic busyMuxValid;
    logic [1:0] busyMuxPair;
    logic busyAluValid;
    logic [1:0] busyAluPair;
    logic writeEnable;
    logic [15:0] writeValue;
    logic [1:0] writePair;
    logic writeWide;
    logic writeHalf;

    commandIssue issue0 (
        .clk(clk),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmd(cmd),
        .stageReady(stageReady),
        .busyMuxValid(busyMuxValid),
        .busyMuxPair(busyMuxPair),
        .busyAluValid(busyAluValid),
        .busyAluPair(busyAluPair),
        .writeEnable(writeEnable),
        .writeValue(writeValue),
        .writePair(writePair),
        .writeWide(writeWide),
        .writeHalf(writeHalf),
        .cmdReady(cmdReady),
        .issueValid(issueValid),
        .issueCmd(issueCmd),
        .pairBus(pairBus)
    );

    pairOperandMux mux0 (
        .clk(clk),
        .reset(reset),
        .issueValid(issueValid),
        .issueCmd(issueCmd),
        .pairBus(pairBus),
        .aluReady(aluReady),
        .stageReady(stageReady),
        .stageOut(muxStage),
        .busyMuxValid(busyMuxValid),
        .busyMuxPair(busyMuxPair)
    );

    aluStage alu0 (
        .clk(clk),
        .reset(reset),
        .stageIn(muxStage),
        .resultReady(resultReady),
        .aluReady(aluReady),
        .resultValid(resultValid),
        .result(result),
        .busyAluValid(busyAluValid),
        .busyAluPair(busyAluPair),
        .writeEnable(writeEnable),
        .writeValue(writeValue),
        .writePair(writePair),
        .writeWide(writeWide),
        .writeHalf(writeHalf)
    );

endmodule

`default_nettype wire

//--- tests/aluPathTop_assert.sv
/* Checks on the result handshake, the reset state
   and the read-after-write stall */
`timescale 1ns/1ns
`default_nettype none
`include "aluPath_cfg.svh"

module aluPathTop_assert import aluPathPkg::*; (
    input wire clk,
    input wire reset,
    input wire cmdValid,
    input wire aluCmdT cmd,
    input wire cmdReady,
    input wire resultValid,
    input wire resultReady,
    input wire aluResultT result,
    input wire muxStageT muxStage
);

    int failures = 0;
    logic readsMuxDst;
    logic readsAluDst;

    function automatic logic usesPair(input aluCmdT c, input logic [1:0] pair);
        return (c.srcHigh.half != `SEL_NONE && c.srcHigh.pair == pair)
            || (c.srcLow.half != `SEL_NONE && c.srcLow.pair == pair);
    endfunction

    assign readsMuxDst = usesPair(cmd, muxStage.dstPair);
    assign readsAluDst = usesPair(cmd, result.dstPair);

    resetClearsResult: assert property (@(posedge clk) reset |=> !resultValid)
        else begin
            failures++;
            $error("resultValid high after reset");
        end

    resultHeldWhileStalled: assert property (@(posedge clk) disable iff (reset)
        (resultValid && !resultReady) |=> (resultValid && $stable(result)))
        else begin
            failures++;
            $error("result changed while resultReady was low");
        end

    // A stage entry leaving on this edge is already written back
    hazardStallsCommand: assert property (@(posedge clk) disable iff (reset)
        (cmdValid && ((muxStage.valid && readsMuxDst)
            || (resultValid && !resultReady && readsAluDst)))
        |-> !cmdReady)
        else begin
            failures++;
            $error("cmdReady high although a register hazard exists");
        end

endmodule

`default_nettype wire

//--- tests/aluPathTop_tb.sv
/* ALU path testbench with vector file reader, register model,
   command driver and result checker under back-pressure */
`timescale 1ns/1ns
`default_nettype none
`include "aluPath_cfg.svh"

module aluPathTop_tb import aluPathPkg::*; ();

    localparam int MaxEntries = 64;
    localparam int WaitLimit = 100;

    logic clk;
    logic reset;
    logic cmdValid;
    aluCmdT cmd;
    logic cmdReady;
    logic resultReady;
    logic resultValid;
    aluResultT result;

    // One entry per vector line in file order
    logic [8*24-1:0] names [MaxEntries];
    logic isLoad [MaxEntries];
    aluCmdT cmds [MaxEntries];
    int stalls [MaxEntries];
    logic [17:0] expected [MaxEntries];
    int entryCount;
    int issuedCount;
    int doneCount;
    int passCount;
    int errorCount;
    logic [7:0] regModel [6];
    logic [1:0] loadPair;
    logic [15:0] loadValue;

    aluPathTop dut0 (
        .clk(clk),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmd(cmd),
        .resultReady(resultReady),
        .cmdReady(cmdReady),
        .resultValid(resultValid),
        .result(result)
    );

    bind aluPathTop aluPathTop_assert assert0 (
        .clk(clk),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmd(cmd),
        .cmdReady(cmdReady),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .result(result),
        .muxStage(muxStage)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    // ********************
    // Register model
    // ********************
    // Registers kept as B C D E H L so a pair is two neighbours
    function automatic logic [15:0] operandOf(input logic [1:0] pair, input logic [1:0] half);
        logic [7:0] hi;
        logic [7:0] lo;
        hi = regModel[2 * pair];
        lo = regModel[2 * pair + 1];
        case (half)
            `SEL_HIGH: return {8'h00, hi};
            `SEL_LOW: return {8'h00, lo};
            `SEL_PAIR: return {hi, lo};
            default: return 16'h0000;
        endcase
    endfunction

    // Returns value, zero and carry
    function automatic logic [17:0] modelExecute(input aluCmdT c);
        logic [16:0] a;
        logic [16:0] b;
        logic [16:0] sum;
        logic [15:0] value;
        logic carryOut;
        a = {1'b0, operandOf(c.srcHigh.pair, c.srcHigh.half)};
        b = {1'b0, operandOf(c.srcLow.pair, c.srcLow.half)};
        if (!c.wide) begin
            a = a & 17'h000FF;
            b = b & 17'h000FF;
        end
        carryOut = 1'b0;
        case (c.op)
            `OP_ADD: begin
                sum = a + b;
                carryOut = c.wide ? sum[16] : sum[8];
            end
            `OP_SUB: begin
                sum = a - b;
                carryOut = a < b;
            end
            `OP_AND: sum = a & b;
            `OP_OR: sum = a | b;
            default: sum = a ^ b;
        endcase
        value = c.wide ? sum[15:0] : {8'h00, sum[7:0]};
        return {value, value == 16'h0000, carryOut};
    endfunction

    task automatic writeModel(input logic [1:0] pair, input logic wide, input logic half,
                              input logic [15:0] value);
        if (wide) begin
            regModel[2 * pair] = value[15:8];
            regModel[2 * pair + 1] = value[7:0];
        end else if (half) begin
            regModel[2 * pair] = value[7:0];
        end else begin
            regModel[2 * pair + 1] = value[7:0];
        end
    endtask

    task automatic readVectors();
        int fd;
        int code;
        logic [8*24-1:0] token;
        logic [8*200-1:0] rest;
        logic [15:0] field [12];
        aluCmdT c;
        logic [17:0] model;
        for (int r = 0; r < 6; r++) begin
            regModel[r] = 8'h00;
        end
        entryCount = 0;
        fd = $fopen("tests/aluPath_tests.txt", "r");
        if (fd == 0) abortRun("cannot open the vector file tests/aluPath_tests.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", token);
            if (code == 1 && token == "#") begin
                code = $fgets(rest, fd);
            end else if (code == 1) begin
                if (entryCount == MaxEntries) abortRun("too many lines in the vector file");
                names[entryCount] = token;
                stalls[entryCount] = 0;
                if (token == "load") begin
                    code = $fscanf(fd, "%h %h", field[0], field[1]);
                    if (code != 2) abortRun("malformed load line in the vector file");
                    isLoad[entryCount] = 1'b1;
                    cmds[entryCount] = '0;
                    cmds[entryCount].dstPair = field[0][1:0];
                    expected[entryCount] = {field[1], 2'b00};
                    writeModel(field[0][1:0], 1'b1, 1'b0, field[1]);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %d %h %h %h",
                                   field[0], field[1], field[2], field[3], field[4], field[5],
                                   field[6], field[7], field[8], field[9], field[10], field[11]);
                    if (code != 12) abortRun($sformatf("malformed vector line %0s", token));
                    c = '0;
                    c.op = field[0][2:0];
                    c.wide = field[1][0];
                    c.srcHigh.pair = field[2][1:0];
                    c.srcHigh.half = field[3][1:0];
                    c.srcLow.pair = field[4][1:0];
                    c.srcLow.half = field[5][1:0];
                    c.dstPair = field[6][1:0];
                    c.dstHalf = field[7][0];
                    isLoad[entryCount] = 1'b0;
                    cmds[entryCount] = c;
                    stalls[entryCount] = field[8];
                    expected[entryCount] = {field[9], field[10][0], field[11][0]};
                    model = modelExecute(c);
                    if (model !== expected[entryCount]) begin
                        $display("%0s: vector file gives %h but the register model gives %h",
                                 token, expected[entryCount], model);
                        errorCount++;
                    end
                    writeModel(c.dstPair, c.wide, c.dstHalf, model[17:2]);
                end
                entryCount++;
            end
        end
        $fclose(fd);
    endtask

    // ********************
    // Command driver
    // ********************
    task automatic driveCommands();
        int waited;
        int idle;
        for (int i = 0; i < entryCount; i++) begin
            idle = $urandom % 3;
            repeat (idle) begin
                @(posedge clk);
                #2;
            end
            if (isLoad[i]) begin
                // Preload through the writeback port once nothing is in flight
                waited = 0;
                while (doneCount != issuedCount) begin
                    waited++;
                    if (waited > WaitLimit) abortRun("timeout waiting for the pipeline to drain");
                    @(negedge clk);
                end
                @(posedge clk);
                #2;
                loadPair = cmds[i].dstPair;
                loadValue = expected[i][17:2];
                force dut0.writeEnable = 1'b1;
                force dut0.writeValue = loadValue;
                force dut0.writePair = loadPair;
                force dut0.writeWide = 1'b1;
                force dut0.writeHalf = 1'b0;
                @(posedge clk);
                #2;
                release dut0.writeEnable;
                release dut0.writeValue;
                release dut0.writePair;
                release dut0.writeWide;
                release dut0.writeHalf;
            end else begin
                cmdValid = 1'b1;
                cmd = cmds[i];
                waited = 0;
                @(negedge clk);
                while (!cmdReady) begin
                    waited++;
                    if (waited > WaitLimit) begin
                        abortRun($sformatf("timeout waiting for cmdReady on %0s", names[i]));
                    end
                    @(negedge clk);
                end
                @(posedge clk);
                #2;
                cmdValid = 1'b0;
                issuedCount++;
            end
        end
    endtask

    // ********************
    // Result monitor
    // ********************
    task automatic collectResults();
        int waited;
        logic unstable;
        aluResultT held;
        logic [17:0] actual;
        logic [3:0] route;
        logic [3:0] expectedRoute;
        for (int i = 0; i < entryCount; i++) begin
            if (!isLoad[i]) begin
                resultReady = (stalls[i] == 0);
                unstable = 1'b0;
                waited = 0;
                @(negedge clk);
                while (!resultValid) begin
                    waited++;
                    if (waited > WaitLimit) begin
                        abortRun($sformatf("timeout waiting for the result of %0s", names[i]));
                    end
                    @(negedge clk);
                end
                held = result;
                for (int s = 0; s < stalls[i]; s++) begin
                    @(posedge clk);
                    #2;
                    if (s == stalls[i] - 1) resultReady = 1'b1;
                    @(negedge clk);
                    if (!resultValid || result !== held) unstable = 1'b1;
                end
                actual = {result.value, result.zero, result.carry};
                // Destination pair, half and width travel with the result
                route = {result.dstPair, result.dstHalf, result.wide};
                expectedRoute = {cmds[i].dstPair, cmds[i].dstHalf, cmds[i].wide};
                if (actual !== expected[i]) begin
                    $display("FAILED %0s: expected %h zero %b carry %b, actual %h zero %b carry %b",
                             names[i], expected[i][17:2], expected[i][1], expected[i][0],
                             actual[17:2], actual[1], actual[0]);
                    errorCount++;
                end else if (route !== expectedRoute) begin
                    $display("FAILED %0s: expected destination %b, actual destination %b",
                             names[i], expectedRoute, route);
                    errorCount++;
                end else if (unstable) begin
                    $display("%0s: result changed or dropped while resultReady was low", names[i]);
                    errorCount++;
                end else begin
                    $display("passed %0s", names[i]);
                    passCount++;
                end
                @(posedge clk);
                #2;
                doneCount++;
            end
        end
    endtask

    task automatic checkNoExtraResults();
        resultReady = 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (resultValid) begin
                $display("unexpected extra result after the last command");
                errorCount++;
            end
        end
    endtask

    initial begin
        void'($urandom(24));
        reset = 1'b1;
        cmdValid = 1'b0;
        cmd = '0;
        resultReady = 1'b0;
        issuedCount = 0;
        doneCount = 0;
        passCount = 0;
        errorCount = 0;
        readVectors();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        fork
            driveCommands();
            collectResults();
        join
        checkNoExtraResults();
        errorCount += dut0.assert0.failures;
        $display("%0d tests passed, %0d errors", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/aluPath_tests.txt
# name op wide srcHighPair srcHighHalf srcLowPair srcLowHalf dstPair dstHalf stall value zero carry
# load pair value : writes a whole pair once the pipeline is empty
addResetBC      0 0 0 1 0 2 2 0 0 0000 1 0
orResetPairs    3 1 1 3 2 3 1 0 0 0000 1 0
load 1 1234
load 2 F0C3
addNarrowB      0 0 1 1 2 2 0 1 0 00D5 0 0
addNarrowC      0 0 2 1 2 2 0 0 0 00B3 0 1
addWideBCDE     0 1 0 3 1 3 2 0 0 E7E7 0 0
addWideCarry    0 1 2 3 0 3 1 0 0 BD9A 0 1
subNarrowBorrow 1 0 1 2 0 1 2 1 0 00C5 0 1
subNarrowZero   1 0 2 2 2 2 1 0 0 0000 1 0
andNarrowHigh   2 0 0 1 2 1 0 0 0 00C5 0 0
orNarrowLow     3 0 1 1 1 2 2 0 0 00BD 0 0
xorNarrowZero   4 0 0 2 2 1 1 1 0 0000 1 0
xorWide         4 1 0 3 2 3 0 0 0 1078 0 0
subWideBorrow   1 1 1 3 0 3 2 0 0 EF88 0 1
addNarrowWrap   0 0 2 2 0 2 1 0 0 0000 1 1
andWide         2 1 0 3 2 3 1 0 0 0008 0 0
addWideHighSel  0 1 2 1 1 2 0 0 0 00F7 0 0
stallOr         3 1 2 3 1 3 2 0 4 EF88 0 0
stallSub        1 0 0 2 1 2 0 1 3 00EF 0 0
stallAdd        0 1 1 3 1 3 1 0 0 0010 0 0
xorAfterStall   4 0 0 1 2 1 2 0 2 0000 1 0
addWideFinal    0 1 2 3 0 3 1 0 1 DEF7 0 1
orSelectNone    3 0 1 2 0 0 2 1 0 00F7 0 0

//--- aluPathTop.f
+incdir+src
src/aluPathPkg.sv
src/registerPairFile.sv
src/commandIssue.sv
src/pairOperandMux.sv
src/aluStage.sv
src/aluPathTop.sv
tests/aluPathTop_assert.sv
tests/aluPathTop_tb.sv

//--- Bender.yml
package:
  name: aluPath

export_include_dirs:
  - src

sources:
  - files:
      - src/aluPathPkg.sv
      - src/registerPairFile.sv
      - src/commandIssue.sv
      - src/pairOperandMux.sv
      - src/aluStage.sv
      - src/aluPathTop.sv
  - target: test
    files:
      - tests/aluPathTop_assert.sv
      - tests/aluPathTop_tb.sv
